//--- rtl/bus_pkg.sv
package bus_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////
    localparam int unsigned WORD_W     = 32;
    localparam int unsigned ADR_W      = 8;
    localparam int unsigned BYTE_ADR_W = ADR_W + 2;

    // Byte offsets of the mapped registers
    localparam logic [BYTE_ADR_W-1:0] ADDR_VCTRL     = 10'h008;
    localparam logic [BYTE_ADR_W-1:0] ADDR_VSCRX     = 10'h00C;
    localparam logic [BYTE_ADR_W-1:0] ADDR_VSCRY     = 10'h010;
    localparam logic [BYTE_ADR_W-1:0] ADDR_VIRQLINE  = 10'h014;
    localparam logic [BYTE_ADR_W-1:0] ADDR_KEYBUF    = 10'h01C;
    localparam logic [BYTE_ADR_W-1:0] ADDR_MTIME     = 10'h080;
    localparam logic [BYTE_ADR_W-1:0] ADDR_MTIMEH    = 10'h084;
    localparam logic [BYTE_ADR_W-1:0] ADDR_MTIMECMP  = 10'h088;
    localparam logic [BYTE_ADR_W-1:0] ADDR_MTIMECMPH = 10'h08C;

    ////////////////////////////////////////////////////////////
    // Wishbone classic, word access only
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADR_W-1:0]  adr;
        logic [WORD_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        REG_NONE,
        REG_VCTRL,
        REG_VSCRX,
        REG_VSCRY,
        REG_VIRQLINE,
        REG_KEYBUF,
        REG_MTIME,
        REG_MTIMEH,
        REG_MTIMECMP,
        REG_MTIMECMPH
    } reg_id_e;

    // One register access, valid in the ack cycle
    typedef struct packed {
        logic              valid;
        logic              we;
        reg_id_e           id;
        logic [WORD_W-1:0] wdata;
    } reg_access_t;

endpackage

//--- rtl/key_fifo.sv
`timescale 1ns/1ps

module key_fifo
    import bus_pkg::*, periph_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  key_push_t        push,
    input  reg_access_t      access,
    output logic [KEY_W-1:0] head,
    output logic             empty
);

    logic [KEY_W-1:0]     mem [KEYBUF_DEPTH];
    logic [KEY_PTR_W-1:0] wr_ptr;
    logic [KEY_PTR_W-1:0] rd_ptr;
    logic [KEY_CNT_W-1:0] count;
    logic                 full;
    logic                 push_ok;
    logic                 pop;
    logic                 clear;

    assign full  = (count == KEY_CNT_W'(KEYBUF_DEPTH));
    assign empty = (count == '0);

    // Pushes into a full buffer and pops from an empty one are lost
    assign push_ok = push.valid && !full;
    assign pop     = access.valid && !access.we && access.id == REG_KEYBUF && !empty;
    assign clear   = access.valid && access.we && access.id == REG_KEYBUF;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push.code;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = mem[rd_ptr];

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= KEY_CNT_W'(KEYBUF_DEPTH));

endmodule

//--- rtl/machine_timer.sv
`timescale 1ns/1ps

module machine_timer
    import bus_pkg::*, periph_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  reg_access_t       access,
    output logic [TIME_W-1:0] mtime,
    output logic [TIME_W-1:0] mtimecmp,
    output logic              irq_timer
);

    logic [TICK_W-1:0] presc;
    logic              tick;
    logic              wr;

    assign tick = (presc == TICK_W'(TICK_DIVIDE - 1));
    assign wr   = access.valid && access.we;

    ////////////////////////////////////////////////////////////
    // Millisecond prescaler
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Time and compare
    ////////////////////////////////////////////////////////////
    // A write to either half holds off the tick increment
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mtime <= '0;
        end else if (wr && access.id == REG_MTIME) begin
            mtime[31:0] <= access.wdata;
        end else if (wr && access.id == REG_MTIMEH) begin
            mtime[63:32] <= access.wdata;
        end else if (tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mtimecmp <= '0;
        end else if (wr && access.id == REG_MTIMECMP) begin
            mtimecmp[31:0] <= access.wdata;
        end else if (wr && access.id == REG_MTIMECMPH) begin
            mtimecmp[63:32] <= access.wdata;
        end
    end

    // Interrupt follows the comparison one cycle late
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irq_timer <= 1'b0;
        end else begin
            irq_timer <= (mtimecmp <= mtime);
        end
    end

endmodule

//--- rtl/periph_pkg.sv
package periph_pkg;

    ////////////////////////////////////////////////////////////
    // Machine timer
    ////////////////////////////////////////////////////////////
    // Clocks per tick, short for simulation (25175 on the board)
    localparam int unsigned TICK_DIVIDE = 25;
    localparam int unsigned TICK_W      = $clog2(TICK_DIVIDE);
    localparam int unsigned TIME_W      = 64;

    ////////////////////////////////////////////////////////////
    // Keyboard buffer
    ////////////////////////////////////////////////////////////
    localparam int unsigned KEYBUF_DEPTH = 16;
    localparam int unsigned KEY_PTR_W    = $clog2(KEYBUF_DEPTH);
    localparam int unsigned KEY_CNT_W    = KEY_PTR_W + 1;
    localparam int unsigned KEY_W        = 16;

    typedef struct packed {
        logic             valid;
        logic [KEY_W-1:0] code;
    } key_push_t;

    ////////////////////////////////////////////////////////////
    // Video control
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic       sprites_enable;
        logic       gfx_tilemode;
        logic       gfx_enable;
        logic       text_priority;
        logic       text_mode80;
        logic       text_enable;
        logic [8:0] scroll_x;
        logic [7:0] scroll_y;
        logic [8:0] irq_line;
    } video_ctrl_t;

    typedef struct packed {
        logic       timer;
        logic       keybuf;
        logic [1:0] spare;
    } irq_vec_t;

endpackage

//--- rtl/read_data_mux.sv
`timescale 1ns/1ps

module read_data_mux
    import bus_pkg::*, periph_pkg::*;
(
    input  reg_access_t       access,
    input  logic [TIME_W-1:0] mtime,
    input  logic [TIME_W-1:0] mtimecmp,
    input  logic [KEY_W-1:0]  head,
    input  logic              empty,
    input  video_ctrl_t       vctrl,
    input  logic              irq_timer,
    output logic [WORD_W-1:0] rd_data,
    output irq_vec_t          irq
);

    ////////////////////////////////////////////////////////////
    // Readback formatting
    ////////////////////////////////////////////////////////////
    always_comb begin
        rd_data = '0;
        if (access.valid) begin
            case (access.id)
                REG_VCTRL: begin
                    rd_data = WORD_W'({vctrl.sprites_enable, vctrl.gfx_tilemode,
                                       vctrl.gfx_enable, vctrl.text_priority,
                                       vctrl.text_mode80, vctrl.text_enable});
                end
                REG_VSCRX:     rd_data = WORD_W'(vctrl.scroll_x);
                REG_VSCRY:     rd_data = WORD_W'(vctrl.scroll_y);
                REG_VIRQLINE:  rd_data = WORD_W'(vctrl.irq_line);
                // Empty flag on top, scan code at the bottom
                REG_KEYBUF:    rd_data = {empty, {(WORD_W - KEY_W - 1){1'b0}}, head};
                REG_MTIME:     rd_data = mtime[31:0];
                REG_MTIMEH:    rd_data = mtime[63:32];
                REG_MTIMECMP:  rd_data = mtimecmp[31:0];
                REG_MTIMECMPH: rd_data = mtimecmp[63:32];
                default:       rd_data = '0;
            endcase
        end
    end

    // Interrupt lines
    assign irq = '{timer: irq_timer, keybuf: !empty, spare: 2'b00};

endmodule

//--- rtl/sys_regs_top.sv
`timescale 1ns/1ps

module sys_regs_top
    import bus_pkg::*, periph_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    input  key_push_t   key_push,
    output video_ctrl_t vctrl,
    output irq_vec_t    irq
);

    reg_access_t       access;
    logic [WORD_W-1:0] rd_data;
    logic [TIME_W-1:0] mtime;
    logic [TIME_W-1:0] mtimecmp;
    logic              irq_timer;
    logic [KEY_W-1:0]  key_head;
    logic              key_empty;

    ////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////
    wb_reg_decode u_decode (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .rd_data(rd_data),
        .wb_rsp (wb_rsp),
        .access (access)
    );

    ////////////////////////////////////////////////////////////
    // Register blocks
    ////////////////////////////////////////////////////////////
    machine_timer u_timer (
        .clk      (clk),
        .reset    (reset),
        .access   (access),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .irq_timer(irq_timer)
    );

    key_fifo u_keybuf (
        .clk   (clk),
        .reset (reset),
        .push  (key_push),
        .access(access),
        .head  (key_head),
        .empty (key_empty)
    );

    video_ctrl_regs u_video (
        .clk   (clk),
        .reset (reset),
        .access(access),
        .vctrl (vctrl)
    );

    // Readback and interrupt vector
    read_data_mux u_rdmux (
        .access   (access),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .head     (key_head),
        .empty    (key_empty),
        .vctrl    (vctrl),
        .irq_timer(irq_timer),
        .rd_data  (rd_data),
        .irq      (irq)
    );

endmodule

//--- rtl/video_ctrl_regs.sv
`timescale 1ns/1ps

module video_ctrl_regs
    import bus_pkg::*, periph_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  reg_access_t access,
    output video_ctrl_t vctrl
);

    logic wr;

    assign wr = access.valid && access.we;

    // Bits above each field's width are dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vctrl <= '0;
        end else if (wr) begin
            case (access.id)
                REG_VCTRL: begin
                    {vctrl.sprites_enable, vctrl.gfx_tilemode, vctrl.gfx_enable,
                     vctrl.text_priority, vctrl.text_mode80,
                     vctrl.text_enable} <= access.wdata[5:0];
                end
                REG_VSCRX:    vctrl.scroll_x <= access.wdata[8:0];
                REG_VSCRY:    vctrl.scroll_y <= access.wdata[7:0];
                // Raster line that raises the line interrupt
                REG_VIRQLINE: vctrl.irq_line <= access.wdata[8:0];
                default: begin
                end
            endcase
        end
    end

endmodule

//--- rtl/wb_reg_decode.sv
`timescale 1ns/1ps

module wb_reg_decode
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  wb_req_t           wb_req,
    input  logic [WORD_W-1:0] rd_data,
    output wb_rsp_t           wb_rsp,
    output reg_access_t       access
);

    logic              ack_q;
    logic              accept;
    reg_id_e           id_next;
    reg_id_e           id_q;
    logic              we_q;
    logic [WORD_W-1:0] wdata_q;

    // New cycle only when the previous one has been acknowledged
    assign accept = wb_req.cyc && wb_req.stb && !ack_q;

    // Word address to register
    always_comb begin
        case ({wb_req.adr, 2'b00})
            ADDR_VCTRL:     id_next = REG_VCTRL;
            ADDR_VSCRX:     id_next = REG_VSCRX;
            ADDR_VSCRY:     id_next = REG_VSCRY;
            ADDR_VIRQLINE:  id_next = REG_VIRQLINE;
            ADDR_KEYBUF:    id_next = REG_KEYBUF;
            ADDR_MTIME:     id_next = REG_MTIME;
            ADDR_MTIMEH:    id_next = REG_MTIMEH;
            ADDR_MTIMECMP:  id_next = REG_MTIMECMP;
            ADDR_MTIMECMPH: id_next = REG_MTIMECMPH;
            default:        id_next = REG_NONE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    // Request payload, captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            id_q    <= id_next;
            we_q    <= wb_req.we;
            wdata_q <= wb_req.dat;
        end
    end

    assign access = '{valid: ack_q, we: we_q, id: id_q, wdata: wdata_q};
    assign wb_rsp = '{ack: ack_q, dat: rd_data};

    // Unmapped offsets read as zero
    unmapped_read_zero: assert property (@(posedge clk) disable iff (reset)
        (wb_rsp.ack && !access.we && access.id == REG_NONE) |-> wb_rsp.dat == '0);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module tb_sys_regs -Mdir obj_dir -f sources.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sys_regs
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation completed"
exit 0

//--- sources.f
rtl/bus_pkg.sv
rtl/periph_pkg.sv
rtl/wb_reg_decode.sv
rtl/machine_timer.sv
rtl/key_fifo.sv
rtl/video_ctrl_regs.sv
rtl/read_data_mux.sv
rtl/sys_regs_top.sv
test/tb_sys_regs.sv

//--- test/tb_sys_regs.sv
`timescale 1ns/1ps

module tb_sys_regs
    import bus_pkg::*, periph_pkg::*;
();

    localparam int unsigned NUM_ACCESSES = 400;
    // About 3 cycles per access, plus reset and margin
    localparam int unsigned CYCLE_LIMIT  = 4000;

    // Word addresses of the mapped registers, byte offset divided by 4
    localparam logic [7:0] MAP_ADR [9] = '{8'h02, 8'h03, 8'h04, 8'h05, 8'h07,
                                           8'h20, 8'h21, 8'h22, 8'h23};
    localparam reg_id_e    MAP_ID  [9] = '{REG_VCTRL, REG_VSCRX, REG_VSCRY, REG_VIRQLINE,
                                           REG_KEYBUF, REG_MTIME, REG_MTIMEH,
                                           REG_MTIMECMP, REG_MTIMECMPH};

    logic        clk;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    key_push_t   key_push;
    video_ctrl_t vctrl;
    irq_vec_t    irq;

    integer      seed;
    int unsigned cycles;

    ////////////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////////////
    video_ctrl_t      vc_model;
    logic [KEY_W-1:0] key_q[$];
    logic [31:0]      mt_hi;
    logic [31:0]      mt_lo_base;
    int unsigned      mt_lo_cycle;
    logic [31:0]      cmp_hi;
    logic [31:0]      cmp_lo;

    sys_regs_top UUT (
        .clk     (clk),
        .reset   (reset),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .key_push(key_push),
        .vctrl   (vctrl),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run("Run did not finish within the cycle limit");
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            fail_run($sformatf("Mismatch at %0t: %s expected 0x%h got 0x%h",
                               $time, name, exp, got));
    endtask

    function automatic logic is_mapped(input logic [7:0] adr);
        for (int i = 0; i < 9; i++) begin
            if (MAP_ADR[i] == adr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Readback as the register map defines it
    function automatic logic [31:0] expected_read(input reg_id_e id);
        case (id)
            REG_VCTRL:     return {26'd0, vc_model.sprites_enable, vc_model.gfx_tilemode,
                                   vc_model.gfx_enable, vc_model.text_priority,
                                   vc_model.text_mode80, vc_model.text_enable};
            REG_VSCRX:     return {23'd0, vc_model.scroll_x};
            REG_VSCRY:     return {24'd0, vc_model.scroll_y};
            REG_VIRQLINE:  return {23'd0, vc_model.irq_line};
            REG_KEYBUF:    return {16'd0, key_q[0]};
            REG_MTIMEH:    return mt_hi;
            REG_MTIMECMP:  return cmp_lo;
            REG_MTIMECMPH: return cmp_hi;
            default:       return 32'd0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // One Wishbone access, optionally with a key push
    ////////////////////////////////////////////////////////////
    // Push mode 1 lands at acceptance, mode 2 together with the write or pop
    task automatic bus_access(input logic we, input logic [7:0] adr, input reg_id_e id,
                              input logic [31:0] data, input int push_mode,
                              input logic [KEY_W-1:0] code);
        logic [31:0] rdata;
        logic [63:0] t_min;
        logic [63:0] t_max;
        logic [63:0] cmp;
        int unsigned elapsed;
        logic        was_full;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: data};
        if (push_mode == 1) begin
            key_push <= '{valid: 1'b1, code: code};
        end
        @(negedge clk);
        assert (!wb_rsp.ack) else fail_run("Ack rose before the request was accepted");
        @(posedge clk);
        if (push_mode == 2) begin
            key_push <= '{valid: 1'b1, code: code};
        end else begin
            key_push <= '0;
        end
        if (push_mode == 1 && key_q.size() < KEYBUF_DEPTH) begin
            key_q.push_back(code);
        end
        @(negedge clk);
        assert (wb_rsp.ack) else fail_run("No ack in the cycle after acceptance");
        rdata   = wb_rsp.dat;
        elapsed = cycles - mt_lo_cycle;
        t_min   = {mt_hi, mt_lo_base};
        t_max   = t_min + 64'(elapsed / TICK_DIVIDE) + 64'd1;
        cmp     = {cmp_hi, cmp_lo};
        if (!we) begin
            if (id == REG_MTIME) begin
                assert (rdata >= t_min[31:0] && rdata <= t_max[31:0]) else
                    fail_run($sformatf("Mismatch at %0t: mtime expected 0x%h..0x%h got 0x%h",
                                       $time, t_min[31:0], t_max[31:0], rdata));
            end else if (id == REG_KEYBUF && key_q.size() == 0) begin
                // Head is undefined when empty
                check_value("rd_data(REG_KEYBUF)", rdata & 32'hFFFF_0000, 32'h8000_0000);
            end else begin
                check_value($sformatf("rd_data(%s)", id.name()), rdata, expected_read(id));
            end
        end
        check_value("irq.keybuf", 32'(irq.keybuf), 32'(key_q.size() != 0));
        if (cmp <= t_min) begin
            check_value("irq.timer", 32'(irq.timer), 32'd1);
        end else if (cmp > t_max) begin
            check_value("irq.timer", 32'(irq.timer), 32'd0);
        end
        @(posedge clk);
        wb_req   <= '0;
        key_push <= '0;
        @(negedge clk);
        // Model the edge that ended the ack cycle
        was_full = (key_q.size() >= KEYBUF_DEPTH);
        if (we) begin
            case (id)
                REG_VCTRL: begin
                    {vc_model.sprites_enable, vc_model.gfx_tilemode, vc_model.gfx_enable,
                     vc_model.text_priority, vc_model.text_mode80,
                     vc_model.text_enable} = data[5:0];
                end
                REG_VSCRX:     vc_model.scroll_x = data[8:0];
                REG_VSCRY:     vc_model.scroll_y = data[7:0];
                REG_VIRQLINE:  vc_model.irq_line = data[8:0];
                REG_KEYBUF:    key_q.delete();
                REG_MTIME: begin
                    mt_lo_base  = data;
                    mt_lo_cycle = cycles;
                end
                REG_MTIMEH:    mt_hi = data;
                REG_MTIMECMP:  cmp_lo = data;
                REG_MTIMECMPH: cmp_hi = data;
                default: begin
                end
            endcase
        end else if (id == REG_KEYBUF && key_q.size() != 0) begin
            void'(key_q.pop_front());
        end
        if (push_mode == 2 && !was_full) begin
            key_q.push_back(code);
        end
        assert (!wb_rsp.ack) else fail_run("Ack stayed high for two cycles");
        check_value("vctrl", vctrl, vc_model);
        check_value("irq.keybuf", 32'(irq.keybuf), 32'(key_q.size() != 0));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] extra;
        int unsigned sel;
        int          push_mode;
        logic [7:0]  adr;
        reg_id_e     id;
        seed        = 32'h12cf2972;
        cycles      = 0;
        reset       = 1'b1;
        wb_req      = '0;
        key_push    = '0;
        vc_model    = '0;
        mt_hi       = '0;
        mt_lo_base  = '0;
        mt_lo_cycle = 0;
        cmp_hi      = '0;
        cmp_lo      = '0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value("wb_rsp.ack", 32'(wb_rsp.ack), 32'd0);
        check_value("irq", 32'(irq), 32'd0);
        check_value("vctrl", vctrl, 32'd0);
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        mt_lo_cycle = cycles;

        // Compare far above time, then back to zero
        bus_access(1'b1, 8'h23, REG_MTIMECMPH, 32'hFFFF_FFFF, 0, '0);
        bus_access(1'b0, 8'h21, REG_MTIMEH, 32'd0, 0, '0);
        bus_access(1'b1, 8'h23, REG_MTIMECMPH, 32'd0, 0, '0);
        bus_access(1'b1, 8'h22, REG_MTIMECMP, 32'd0, 0, '0);
        bus_access(1'b0, 8'h20, REG_MTIME, 32'd0, 0, '0);

        for (int i = 0; i < NUM_ACCESSES; i++) begin
            r     = $random(seed);
            data  = $random(seed);
            extra = $random(seed);
            sel   = r % 32'd12;
            if (sel < 9) begin
                adr = MAP_ADR[sel];
                id  = MAP_ID[sel];
            end else begin
                adr = is_mapped(extra[7:0]) ? 8'h06 : extra[7:0];
                id  = REG_NONE;
            end
            // Low time stays below 2^31 so no tick carries into the high half
            case (id)
                REG_MTIME:     data = r[24] ? {24'd0, data[7:0]} : {1'b0, data[30:0]};
                REG_MTIMECMP:  data = r[24] ? {24'd0, data[7:0]} : data;
                REG_MTIMEH,
                REG_MTIMECMPH: data = r[25] ? 32'd0 : data;
                default: begin
                end
            endcase
            push_mode = (r[23:22] == 2'd3) ? 0 : int'(r[23:22]);
            if (r[20] && id == REG_KEYBUF) begin
                push_mode = 0;
            end
            bus_access(r[20], adr, id, data, push_mode, extra[31:16]);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule
